// File: hw/mrdma_pkg.sv
// addresses are in 16-byte atoms; one batch only; in_precision other than int8 walks as int16
package mrdma_pkg;

  // ==================================================
  // widths
  // ==================================================
  // low address bits dropped from base and strides
  localparam int unsigned atom_shift  = 4;
  localparam int unsigned addr_w      = 64;
  localparam int unsigned atom_addr_w = addr_w - atom_shift;
  localparam int unsigned stride_w    = 28;
  // width, height, channel register fields
  localparam int unsigned dim_w       = 13;
  // channel block counter
  localparam int unsigned surf_cnt_w  = 10;
  localparam int unsigned req_size_w  = 15;
  localparam int unsigned cq_size_w   = 13;
  localparam int unsigned stall_w     = 32;

  // ==================================================
  // input precision codes
  // ==================================================
  localparam logic [1:0] prec_int8  = 2'd0;
  localparam logic [1:0] prec_int16 = 2'd1;

  // ==================================================
  // structs
  // ==================================================
  // register view of one operation
  typedef struct packed {
    logic [31:0]             base_addr_high;
    logic [27:0]             base_addr_low;
    logic [stride_w-1:0]     line_stride;
    logic [stride_w-1:0]     surf_stride;
    logic [dim_w-1:0]        width;
    logic [dim_w-1:0]        height;
    logic [dim_w-1:0]        channel;
    logic [1:0]              in_precision;
    logic                    perf_dma_en;
  } mrdma_cfg_t;

  // size sits above addr, same bit layout as the dma pd bus
  typedef struct packed {
    logic [req_size_w-1:0]   size;
    logic [addr_w-1:0]       addr;
  } dma_rd_req_t;

  // cube_end on the top bit of the cq entry
  typedef struct packed {
    logic                    cube_end;
    logic [cq_size_w-1:0]    size;
  } cq_cmd_t;

endpackage

// File: hw/mrdma_cube_walk.sv
// cfg must stay stable for the whole operation; counters return to zero only at cube end
`timescale 1ns/1ps

module mrdma_cube_walk
  import mrdma_pkg::*;
(
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  mrdma_cfg_t            cfg,
  input  logic                  accept,
  output logic                  surf_end,
  output logic                  cube_end,
  output logic [req_size_w-1:0] req_size
);

  logic                  pack_1x1;
  logic [surf_cnt_w-1:0] surf_limit;
  logic [surf_cnt_w-1:0] count_c;
  logic [dim_w-1:0]      count_h;
  logic                  last_c;
  logic                  last_h;

  // ==================================================
  // config decode
  // ==================================================
  // 1x1 pack when both spatial dims are zero
  assign pack_1x1 = (cfg.width == '0) && (cfg.height == '0);

  // channel blocks per cube, minus one
  always_comb begin
    if (cfg.in_precision == prec_int8) begin
      // 16 channels per block
      surf_limit = {1'b0, cfg.channel[dim_w-1:4]};
    end else begin
      // 8 channels per block
      surf_limit = cfg.channel[dim_w-1:3];
    end
  end

  // ==================================================
  // channel and line counters
  // ==================================================
  assign last_c = (count_c == surf_limit);
  assign last_h = (count_h == cfg.height);

  // pack mode ends surface and cube on its single request
  assign surf_end = pack_1x1 || last_h;
  assign cube_end = surf_end && (pack_1x1 || last_c);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
      count_h <= '0;
    end else if (accept) begin
      // surface step
      if (cube_end) begin
        count_c <= '0;
      end else if (surf_end) begin
        count_c <= count_c + 1'b1;
      end
      // line step, every request is one line
      if (surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

  // ==================================================
  // request size, atoms minus one
  // ==================================================
  // pack mode reads all channel blocks in one go
  assign req_size = pack_1x1 ? req_size_w'(surf_limit) : req_size_w'(cfg.width);

endmodule

// File: hw/mrdma_addr_gen.sv
// addresses in atoms; base and strides must not wrap 60 bits, carry bits flag it for checking
`timescale 1ns/1ps

module mrdma_addr_gen
  import mrdma_pkg::*;
(
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  mrdma_cfg_t             cfg,
  input  logic                   op_load,
  input  logic                   accept,
  input  logic                   surf_end,
  output logic [atom_addr_w-1:0] line_addr
);

  logic [atom_addr_w-1:0] cfg_base;
  logic [atom_addr_w-1:0] base_line;
  logic [atom_addr_w-1:0] base_surf;
  logic [atom_addr_w-1:0] next_surf;
  logic                   next_surf_c;
  // overflow monitors
  logic                   line_carry;
  logic                   surf_carry;

  assign cfg_base = {cfg.base_addr_high, cfg.base_addr_low};

  // next surface start, shared by both registers
  assign {next_surf_c, next_surf} = {1'b0, base_surf} + cfg.surf_stride;

  // ==================================================
  // line and surface base registers
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_line  <= '0;
      base_surf  <= '0;
      line_carry <= 1'b0;
      surf_carry <= 1'b0;
    end else if (op_load) begin
      base_line  <= cfg_base;
      base_surf  <= cfg_base;
      line_carry <= 1'b0;
      surf_carry <= 1'b0;
    end else if (accept) begin
      if (surf_end) begin
        // jump to next surface
        base_line  <= next_surf;
        base_surf  <= next_surf;
        line_carry <= next_surf_c;
        surf_carry <= next_surf_c;
      end else begin
        {line_carry, base_line} <= {1'b0, base_line} + cfg.line_stride;
      end
    end
  end

  assign line_addr = base_line;

endmodule

// File: hw/mrdma_req_issue.sv
// dma and cq are taken only together; both valids depend combinationally on the other side's ready
`timescale 1ns/1ps

module mrdma_req_issue
  import mrdma_pkg::*;
(
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   op_load,
  input  logic                   cube_end,
  input  logic [req_size_w-1:0]  req_size,
  input  logic [atom_addr_w-1:0] line_addr,
  output logic                   dma_rd_req_vld,
  output dma_rd_req_t            dma_rd_req_pd,
  input  logic                   dma_rd_req_rdy,
  output logic                   cq_vld,
  output cq_cmd_t                cq_pd,
  input  logic                   cq_rdy,
  output logic                   accept
);

  logic op_active;

  // ==================================================
  // operation state
  // ==================================================
  // set by load, cleared after the last request goes out
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_active <= 1'b0;
    end else if (op_load) begin
      op_active <= 1'b1;
    end else if (accept && cube_end) begin
      op_active <= 1'b0;
    end
  end

  // ==================================================
  // joint handshake
  // ==================================================
  // each valid held low until the other side can take
  assign dma_rd_req_vld = op_active && cq_rdy;
  assign cq_vld         = op_active && dma_rd_req_rdy;

  // one accept moves both channels
  assign accept = dma_rd_req_vld && dma_rd_req_rdy;

  // ==================================================
  // payloads
  // ==================================================
  // atom address back to bytes
  assign dma_rd_req_pd.addr = {line_addr, {atom_shift{1'b0}}};
  assign dma_rd_req_pd.size = req_size;

  // cq keeps the low size bits only
  assign cq_pd.size     = req_size[cq_size_w-1:0];
  assign cq_pd.cube_end = cube_end;

endmodule

// File: hw/mrdma_stall_cnt.sv
// counts stalled dma request cycles; enable sampled only at op_load, count wraps at 32 bits
`timescale 1ns/1ps

module mrdma_stall_cnt
  import mrdma_pkg::*;
(
  input  logic               nvdla_core_clk,
  input  logic               nvdla_core_rstn,
  input  logic               op_load,
  input  logic               perf_en,
  input  logic               dma_vld,
  input  logic               dma_rdy,
  output logic [stall_w-1:0] stall_count
);

  logic cnt_en;
  logic stall;

  // request offered but not taken
  assign stall = dma_vld && !dma_rdy;

  // enable captured per operation
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_en <= 1'b0;
    end else if (op_load) begin
      cnt_en <= perf_en;
    end
  end

  // clear on load regardless of enable
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_count <= '0;
    end else if (op_load) begin
      stall_count <= '0;
    end else if (cnt_en && stall) begin
      stall_count <= stall_count + 1'b1;
    end
  end

endmodule

// File: hw/mrdma_ig.sv
// mrdma ingress top; cfg held stable from op_load until the cube_end request is taken
`timescale 1ns/1ps

module mrdma_ig
  import mrdma_pkg::*;
(
  input  logic               nvdla_core_clk,
  input  logic               nvdla_core_rstn,
  input  mrdma_cfg_t         cfg,
  input  logic               op_load,
  output logic               dma_rd_req_vld,
  output dma_rd_req_t        dma_rd_req_pd,
  input  logic               dma_rd_req_rdy,
  output logic               cq_vld,
  output cq_cmd_t            cq_pd,
  input  logic               cq_rdy,
  output logic [stall_w-1:0] stall_count
);

  logic                   accept;
  logic                   surf_end;
  logic                   cube_end;
  logic [req_size_w-1:0]  req_size;
  logic [atom_addr_w-1:0] line_addr;

  // ==================================================
  // walk and address
  // ==================================================
  mrdma_cube_walk u_cube_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .accept          (accept),
    .surf_end        (surf_end),
    .cube_end        (cube_end),
    .req_size        (req_size)
  );

  mrdma_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .op_load         (op_load),
    .accept          (accept),
    .surf_end        (surf_end),
    .line_addr       (line_addr)
  );

  // ==================================================
  // issue and perf
  // ==================================================
  mrdma_req_issue u_req_issue (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cube_end        (cube_end),
    .req_size        (req_size),
    .line_addr       (line_addr),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_pd   (dma_rd_req_pd),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .cq_vld          (cq_vld),
    .cq_pd           (cq_pd),
    .cq_rdy          (cq_rdy),
    .accept          (accept)
  );

  mrdma_stall_cnt u_stall_cnt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .perf_en         (cfg.perf_dma_en),
    .dma_vld         (dma_rd_req_vld),
    .dma_rdy         (dma_rd_req_rdy),
    .stall_count     (stall_count)
  );

endmodule

// File: test/mrdma_ig_asserts.sv
// bound into mrdma_ig; reads the active state and address carry bits through bind ports
`timescale 1ns/1ps

module mrdma_ig_asserts (
  input logic nvdla_core_clk,
  input logic nvdla_core_rstn,
  input logic op_active,
  input logic line_carry,
  input logic surf_carry,
  input logic dma_vld,
  input logic dma_rdy,
  input logic cq_vld,
  input logic cq_rdy
);

  // no transfer outside an operation
  a_accept_active: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_vld && dma_rdy) |-> op_active)
    else $error("dma transfer while operation inactive");

  // line and surface bases stay inside 60 bits
  a_no_carry: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(line_carry || surf_carry))
    else $error("address register overflow");

  // dma and cq always move together
  a_joint_xfer: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_vld && dma_rdy) == (cq_vld && cq_rdy))
    else $error("dma and cq transfers differ");

endmodule

bind mrdma_ig mrdma_ig_asserts u_asserts (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .op_active       (u_req_issue.op_active),
  .line_carry      (u_addr_gen.line_carry),
  .surf_carry      (u_addr_gen.surf_carry),
  .dma_vld         (dma_rd_req_vld),
  .dma_rdy         (dma_rd_req_rdy),
  .cq_vld          (cq_vld),
  .cq_rdy          (cq_rdy)
);

// File: test/tb_mrdma_ig.sv
// one batch only; readies random from a fixed seed; expected stream rebuilt from the walk rules
`timescale 1ns/1ps

module tb_mrdma_ig
  import mrdma_pkg::*;
();

  localparam int unsigned n_rows      = 6;
  localparam int unsigned max_cycles  = 4000;
  localparam int unsigned idle_cycles = 6;

  // one table row per operation with back-pressure in percent
  typedef struct packed {
    logic [dim_w-1:0]    width;
    logic [dim_w-1:0]    height;
    logic [dim_w-1:0]    channel;
    logic [1:0]          prec;
    logic [31:0]         base_hi;
    logic [27:0]         base_lo;
    logic [stride_w-1:0] line_stride;
    logic [stride_w-1:0] surf_stride;
    logic                perf_en;
    logic [6:0]          dma_bp;
    logic [6:0]          cq_bp;
  } row_t;

  logic               nvdla_core_clk;
  logic               nvdla_core_rstn;
  mrdma_cfg_t         cfg;
  logic               op_load;
  logic               dma_rd_req_vld;
  dma_rd_req_t        dma_rd_req_pd;
  logic               dma_rd_req_rdy;
  logic               cq_vld;
  cq_cmd_t            cq_pd;
  logic               cq_rdy;
  logic [stall_w-1:0] stall_count;
  dma_rd_req_t        exp_dma [$];
  cq_cmd_t            exp_cq [$];

  // ==================================================
  // stimulus table
  // ==================================================
  // rows 0/1 and 2/3 share channel but differ in precision
  row_t rows [n_rows] = '{
    '{13'd7, 13'd3, 13'd31, prec_int8, 32'h0, 28'h100, 28'h10, 28'h80, 1'b1, 7'd30, 7'd20},
    '{13'd7, 13'd3, 13'd31, prec_int16, 32'h2, 28'h40, 28'h8, 28'h100, 1'b0, 7'd50, 7'd0},
    '{13'd0, 13'd0, 13'd100, prec_int8, 32'h1, 28'habcdef, 28'h0, 28'h0, 1'b1, 7'd40, 7'd40},
    '{13'd0, 13'd0, 13'd100, prec_int16, 32'h5, 28'h10, 28'h0, 28'h0, 1'b1, 7'd0, 7'd0},
    '{13'd15, 13'd0, 13'd63, prec_int16, 32'hff, 28'hfff0000, 28'h4, 28'h200, 1'b1, 7'd60, 7'd10},
    '{13'd3, 13'd5, 13'd15, prec_int8, 32'h0, 28'h800, 28'h20, 28'h400, 1'b0, 7'd25, 7'd25}
  };

  mrdma_ig dut (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .op_load         (op_load),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_pd   (dma_rd_req_pd),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .cq_vld          (cq_vld),
    .cq_pd           (cq_pd),
    .cq_rdy          (cq_rdy),
    .stall_count     (stall_count)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ==================================================
  // reporting and compares
  // ==================================================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_dma(input dma_rd_req_t got, input dma_rd_req_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch dma_rd_req_pd: addr %h size %h, expected addr %h size %h",
                         got.addr, got.size, exp.addr, exp.size));
    end
  endtask

  task automatic check_cq(input cq_cmd_t got, input cq_cmd_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch cq_pd: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_stall(input logic [stall_w-1:0] got, input logic [stall_w-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch stall_count: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // ==================================================
  // reference model
  // ==================================================
  // channel blocks minus one with 16 per block for int8 and 8 otherwise
  function automatic logic [surf_cnt_w-1:0] block_limit(input row_t r);
    if (r.prec == prec_int8) begin
      return surf_cnt_w'(r.channel >> 4);
    end
    return surf_cnt_w'(r.channel >> 3);
  endfunction

  function automatic void build_expected(input row_t r);
    logic [surf_cnt_w-1:0]  lim;
    logic [atom_addr_w-1:0] atom;
    dma_rd_req_t            req;
    cq_cmd_t                cmd;
    exp_dma.delete();
    exp_cq.delete();
    lim = block_limit(r);
    for (int s = 0; s <= int'(lim); s++) begin
      for (int h = 0; h <= int'(r.height); h++) begin
        atom = {r.base_hi, r.base_lo} + atom_addr_w'(s) * atom_addr_w'(r.surf_stride)
             + atom_addr_w'(h) * atom_addr_w'(r.line_stride);
        req.addr     = addr_w'(atom) << atom_shift;
        req.size     = req_size_w'(r.width);
        cmd.cube_end = (s == int'(lim)) && (h == int'(r.height));
        // pack mode issues one request over all blocks
        if (r.width == '0 && r.height == '0) begin
          req.size     = req_size_w'(lim);
          cmd.cube_end = 1'b1;
        end
        cmd.size = req.size[cq_size_w-1:0];
        exp_dma.push_back(req);
        exp_cq.push_back(cmd);
        if (cmd.cube_end) begin
          return;
        end
      end
    end
  endfunction

  // ==================================================
  // per-row run
  // ==================================================
  task automatic drive_readies(input row_t r);
    dma_rd_req_rdy = ($urandom % 100) >= 32'(r.dma_bp);
    cq_rdy         = ($urandom % 100) >= 32'(r.cq_bp);
  endtask

  task automatic run_row(input row_t r);
    int unsigned        sent;
    int unsigned        cycles;
    logic [stall_w-1:0] exp_stall;
    build_expected(r);
    sent      = 0;
    cycles    = 0;
    exp_stall = '0;
    @(negedge nvdla_core_clk);
    cfg.base_addr_high = r.base_hi;
    cfg.base_addr_low  = r.base_lo;
    cfg.line_stride    = r.line_stride;
    cfg.surf_stride    = r.surf_stride;
    cfg.width          = r.width;
    cfg.height         = r.height;
    cfg.channel        = r.channel;
    cfg.in_precision   = r.prec;
    cfg.perf_dma_en    = r.perf_en;
    op_load            = 1'b1;
    @(negedge nvdla_core_clk);
    op_load = 1'b0;
    drive_readies(r);
    #1;
    // load clears the count
    check_stall(stall_count, '0);
    while (sent < exp_dma.size()) begin
      if (cycles >= max_cycles) begin
        fail_run("timeout: cube_end request never transferred");
      end
      // valids follow the other side's ready while active
      check_valid("dma_rd_req_vld", dma_rd_req_vld, cq_rdy);
      check_valid("cq_vld", cq_vld, dma_rd_req_rdy);
      check_dma(dma_rd_req_pd, exp_dma[sent]);
      check_cq(cq_pd, exp_cq[sent]);
      if (r.perf_en && cq_rdy && !dma_rd_req_rdy) begin
        exp_stall = exp_stall + 1'b1;
      end
      if (cq_rdy && dma_rd_req_rdy) begin
        sent++;
      end
      cycles++;
      @(negedge nvdla_core_clk);
      drive_readies(r);
      #1;
    end
    // quiet after cube end
    for (int i = 0; i < int'(idle_cycles); i++) begin
      check_valid("dma_rd_req_vld", dma_rd_req_vld, 1'b0);
      check_valid("cq_vld", cq_vld, 1'b0);
      @(negedge nvdla_core_clk);
      drive_readies(r);
      #1;
    end
    check_stall(stall_count, exp_stall);
  endtask

  initial begin
    void'($urandom(32'ha706));
    cfg             = '0;
    op_load         = 1'b0;
    dma_rd_req_rdy  = 1'b0;
    cq_rdy          = 1'b0;
    nvdla_core_rstn = 1'b0;
    repeat (3) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    #1;
    check_stall(stall_count, '0);
    for (int i = 0; i < int'(n_rows); i++) begin
      run_row(rows[i]);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

// File: sources.f
hw/mrdma_pkg.sv
hw/mrdma_cube_walk.sv
hw/mrdma_addr_gen.sv
hw/mrdma_req_issue.sv
hw/mrdma_stall_cnt.sv
hw/mrdma_ig.sv
test/mrdma_ig_asserts.sv
test/tb_mrdma_ig.sv

// File: Makefile
SRCS := $(shell cat sources.f)
BIN  := obj_dir/Vtb_mrdma_ig

.PHONY: run clean

run: $(BIN)
	-./$(BIN) > sim.log 2>&1
	@cat sim.log
	@! grep -qF '** FAIL **' sim.log
	@grep -qF '** PASS **' sim.log

$(BIN): sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_mrdma_ig -o Vtb_mrdma_ig

clean:
	rm -rf obj_dir sim.log
